// File: filelist.f
source/core_pkg.sv
source/bus_pkg.sv
source/register_file.sv
source/reorder_buffer.sv
source/combo_alu.sv
source/combo_mul.sv
source/ooo_core.sv
dv/tb_ooo_core.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_ooo_core and scan $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module tb_ooo_core -f filelist.f --Mdir obj_dir -o sim
	-./obj_dir/sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_ooo_core.sv
// directed testbench; final registers are read through dut.u_reg_file, and tags assume an 8-entry ROB
module tb_ooo_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROB_SIZE_BITS = 3;
  localparam int ROB_SIZE      = 1 << ROB_SIZE_BITS;
  localparam int WAIT_LIMIT    = 2000;

  logic             i_clock;
  logic             i_reset;
  logic             i_issue_valid;
  bus_pkg::issue_t  i_issue;
  logic             o_full;
  logic             o_retire_valid;
  bus_pkg::retire_t o_retire;

  core_pkg::word_t  model_regs [core_pkg::REG_COUNT];
  bus_pkg::retire_t expected_q [$];
  int               issue_count;
  int               retire_count;
  int               error_count;
  int               test_count;
  logic             saw_full;

  ooo_core #(
    .ROB_SIZE_BITS(ROB_SIZE_BITS),
    .ALU_RS_DEPTH (4),
    .MUL_RS_DEPTH (2)
  ) dut (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_issue_valid (i_issue_valid),
    .i_issue       (i_issue),
    .o_full        (o_full),
    .o_retire_valid(o_retire_valid),
    .o_retire      (o_retire)
  );

  always #10 i_clock = ~i_clock;

  // instruction set rules; ADDI ignores rs2 and MUL keeps the low word
  function automatic core_pkg::word_t predict_result(core_pkg::opcode_e op, core_pkg::word_t a,
                                                     core_pkg::word_t b, core_pkg::word_t imm);
    case (op)
      core_pkg::OP_ADD:  return a + b;
      core_pkg::OP_SUB:  return a - b;
      core_pkg::OP_AND:  return a & b;
      core_pkg::OP_OR:   return a | b;
      core_pkg::OP_XOR:  return a ^ b;
      core_pkg::OP_ADDI: return a + imm;
      default:           return a * b;
    endcase
  endfunction

  task automatic compare_retire(bus_pkg::retire_t got, bus_pkg::retire_t want);
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0d ns o_retire got rd=%0d tag=%0d %h, expected rd=%0d tag=%0d %h",
               $time, got.rd, got.tag, got.value, want.rd, want.tag, want.value);
    end
  endtask

  task automatic compare_value(string name, core_pkg::word_t got, core_pkg::word_t want);
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0d ns %s got %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic compare_count(string name, int got, int want);
    if (got != want) begin
      error_count++;
      $display("[FAIL] %0d ns %s got %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic fail_on_timeout(string what);
    $display("timeout: %s did not finish within %0d cycles", what, WAIT_LIMIT);
    $display("Checks failed");
    $finish;
  endtask

  // called just after a falling edge; the model is updated in program order
  task automatic issue_instr(core_pkg::opcode_e op, core_pkg::reg_idx_t rd,
                             core_pkg::reg_idx_t rs1, core_pkg::reg_idx_t rs2,
                             core_pkg::word_t imm);
    int               waited;
    bus_pkg::retire_t want;
    waited        = 0;
    i_issue_valid = 1'b1;
    i_issue       = '{opcode: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
    while (o_full) begin
      saw_full = 1'b1;
      @(negedge i_clock);
      waited++;
      if (waited > WAIT_LIMIT) fail_on_timeout("issue stall");
    end
    want.rd    = rd;
    want.tag   = core_pkg::tag_t'(issue_count % ROB_SIZE);
    want.value = predict_result(op, model_regs[rs1], model_regs[rs2], imm);
    model_regs[rd] = want.value;
    expected_q.push_back(want);
    issue_count++;
    @(negedge i_clock);
    i_issue_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(negedge i_clock);
      waited++;
      if (waited > WAIT_LIMIT) fail_on_timeout("retirement drain");
    end
    // a few idle cycles let a stray or repeated retirement show up
    repeat (ROB_SIZE) @(negedge i_clock);
  endtask

  task automatic check_registers();
    for (int r = 0; r < core_pkg::REG_COUNT; r++) begin
      compare_value($sformatf("dut.u_reg_file.value_q[%0d]", r), dut.u_reg_file.value_q[r],
                    model_regs[r]);
    end
  endtask

  task automatic finish_test(string name, int errors_before);
    test_count++;
    if (error_count == errors_before) $display("test %0d %s: ok", test_count, name);
    else $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
  endtask

  // every retirement is matched against the oldest outstanding prediction
  always @(posedge i_clock) begin
    bus_pkg::retire_t want;
    if (!i_reset && o_retire_valid) begin
      retire_count++;
      if (expected_q.size() == 0) begin
        error_count++;
        $display("%0d ns: tag %0d retired with no instruction outstanding", $time, o_retire.tag);
      end else begin
        want = expected_q.pop_front();
        compare_retire(o_retire, want);
      end
    end
  end

  task automatic test_independent_alu();
    int errors_before;
    errors_before = error_count;
    issue_instr(core_pkg::OP_ADDI, 3'd1, 3'd0, 3'd0, 32'd10);
    issue_instr(core_pkg::OP_ADDI, 3'd2, 3'd0, 3'd0, 32'd20);
    issue_instr(core_pkg::OP_ADDI, 3'd3, 3'd0, 3'd0, 32'h0000_003c);
    issue_instr(core_pkg::OP_ADDI, 3'd4, 3'd0, 3'd0, 32'hffff_ffff);
    issue_instr(core_pkg::OP_AND,  3'd6, 3'd0, 3'd0, 32'd0);
    issue_instr(core_pkg::OP_XOR,  3'd7, 3'd0, 3'd0, 32'd0);
    wait_drain();
    check_registers();
    finish_test("independent alu", errors_before);
  endtask

  task automatic test_raw_chain();
    int errors_before;
    errors_before = error_count;
    issue_instr(core_pkg::OP_ADDI, 3'd1, 3'd1, 3'd0, 32'd7);
    issue_instr(core_pkg::OP_ADD,  3'd2, 3'd1, 3'd1, 32'd0);
    issue_instr(core_pkg::OP_SUB,  3'd3, 3'd2, 3'd1, 32'd0);
    issue_instr(core_pkg::OP_XOR,  3'd4, 3'd3, 3'd2, 32'd0);
    issue_instr(core_pkg::OP_OR,   3'd5, 3'd4, 3'd1, 32'd0);
    issue_instr(core_pkg::OP_AND,  3'd6, 3'd5, 3'd2, 32'd0);
    wait_drain();
    check_registers();
    finish_test("raw chain", errors_before);
  endtask

  // the ALU entries finish under the multiply latency but still retire behind it
  task automatic test_mul_then_alu();
    int errors_before;
    errors_before = error_count;
    issue_instr(core_pkg::OP_MUL,  3'd3, 3'd1, 3'd2, 32'd0);
    issue_instr(core_pkg::OP_ADDI, 3'd4, 3'd0, 3'd0, 32'd11);
    issue_instr(core_pkg::OP_XOR,  3'd5, 3'd1, 3'd2, 32'd0);
    issue_instr(core_pkg::OP_OR,   3'd6, 3'd1, 3'd4, 32'd0);
    wait_drain();
    check_registers();
    finish_test("mul then alu", errors_before);
  endtask

  task automatic test_mul_dependent_add();
    int errors_before;
    errors_before = error_count;
    issue_instr(core_pkg::OP_MUL, 3'd3, 3'd2, 3'd4, 32'd0);
    issue_instr(core_pkg::OP_ADD, 3'd5, 3'd3, 3'd1, 32'd0);
    wait_drain();
    check_registers();
    finish_test("mul dependent add", errors_before);
  endtask

  // a dependent chain keeps the multiply station occupied until it reports full
  task automatic test_mul_burst();
    int errors_before;
    int retired_before;
    int issued_before;
    errors_before  = error_count;
    retired_before = retire_count;
    issued_before  = issue_count;
    saw_full       = 1'b0;
    for (int i = 0; i < 6; i++) begin
      issue_instr(core_pkg::OP_MUL, 3'd1, 3'd1, 3'd2, 32'd0);
    end
    wait_drain();
    if (!saw_full) begin
      error_count++;
      $display("o_full never rose during the multiply burst");
    end
    compare_count("burst retirements", retire_count - retired_before, issue_count - issued_before);
    check_registers();
    finish_test("mul burst", errors_before);
  endtask

  task automatic test_random_mix();
    int                 errors_before;
    int                 retired_before;
    logic [2:0]         op_bits;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::word_t    imm;
    errors_before  = error_count;
    retired_before = retire_count;
    for (int i = 0; i < 200; i++) begin
      op_bits = 3'($urandom_range(6, 0));
      rd      = core_pkg::reg_idx_t'($urandom_range(7, 0));
      rs1     = core_pkg::reg_idx_t'($urandom_range(7, 0));
      rs2     = core_pkg::reg_idx_t'($urandom_range(7, 0));
      imm     = $urandom();
      issue_instr(core_pkg::opcode_e'(op_bits), rd, rs1, rs2, imm);
    end
    wait_drain();
    compare_count("random retirements", retire_count - retired_before, 200);
    check_registers();
    finish_test("random mix", errors_before);
  endtask

  initial begin
    i_clock       = 1'b0;
    i_reset       = 1'b1;
    i_issue_valid = 1'b0;
    i_issue       = '0;
    issue_count   = 0;
    retire_count  = 0;
    error_count   = 0;
    test_count    = 0;
    saw_full      = 1'b0;
    for (int r = 0; r < core_pkg::REG_COUNT; r++) model_regs[r] = '0;
    void'($urandom(5));
    repeat (3) @(negedge i_clock);
    i_reset = 1'b0;
    test_independent_alu();
    test_raw_chain();
    test_mul_then_alu();
    test_mul_dependent_add();
    test_mul_burst();
    test_random_mix();
    $display("%0d tests, %0d issued, %0d retired, %0d errors",
             test_count, issue_count, retire_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: source/ooo_core.sv
// top of the cluster; issue stalls on any full unit, and the retire port has no back-pressure
module ooo_core #(
  parameter int ROB_SIZE_BITS = 3,
  parameter int ALU_RS_DEPTH  = 4,
  parameter int MUL_RS_DEPTH  = 2
) (
  input  logic             i_clock,
  input  logic             i_reset,
  input  logic             i_issue_valid,
  input  bus_pkg::issue_t  i_issue,
  output logic             o_full,
  output logic             o_retire_valid,
  output bus_pkg::retire_t o_retire
);

  logic               accept;
  core_pkg::tag_t     alloc_tag;
  bus_pkg::operand_t  rs1_operand;
  bus_pkg::operand_t  rs2_operand;
  bus_pkg::dispatch_t dispatch;
  bus_pkg::cdb_t      cdb;
  bus_pkg::cdb_req_t  alu_req;
  bus_pkg::cdb_req_t  mul_req;
  logic               alu_grant;
  logic               full_rob;
  logic               full_alu;
  logic               full_mul;

  // issue stalls for every opcode when the ROB or either station has no free entry
  assign o_full = full_rob | full_alu | full_mul;
  assign accept = i_issue_valid && !o_full;

  always_comb begin
    dispatch.opcode = i_issue.opcode;
    dispatch.tag    = alloc_tag;
    dispatch.op1    = rs1_operand;
    dispatch.op2    = rs2_operand;
    if (i_issue.opcode == core_pkg::OP_ADDI) begin
      dispatch.op2.ready = 1'b1;
      dispatch.op2.tag   = '0;
      dispatch.op2.value = i_issue.imm;
    end
  end

  register_file u_reg_file (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_rename_valid(accept),
    .i_rename_rd   (i_issue.rd),
    .i_rename_tag  (alloc_tag),
    .i_rs1         (i_issue.rs1),
    .i_rs2         (i_issue.rs2),
    .i_cdb         (cdb),
    .o_rs1         (rs1_operand),
    .o_rs2         (rs2_operand)
  );

  reorder_buffer #(
    .ROB_SIZE_BITS(ROB_SIZE_BITS)
  ) u_rob (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_alloc_valid (accept),
    .i_alloc_rd    (i_issue.rd),
    .i_alu_req     (alu_req),
    .i_mul_req     (mul_req),
    .o_alloc_tag   (alloc_tag),
    .o_alu_grant   (alu_grant),
    .o_cdb         (cdb),
    .o_full        (full_rob),
    .o_retire_valid(o_retire_valid),
    .o_retire      (o_retire)
  );

  combo_alu #(
    .ALU_RS_DEPTH(ALU_RS_DEPTH)
  ) u_combo_alu (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_dispatch_valid(accept),
    .i_dispatch      (dispatch),
    .i_cdb           (cdb),
    .i_grant         (alu_grant),
    .o_req           (alu_req),
    .o_full          (full_alu)
  );

  combo_mul #(
    .MUL_RS_DEPTH(MUL_RS_DEPTH)
  ) u_combo_mul (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_dispatch_valid(accept),
    .i_dispatch      (dispatch),
    .i_cdb           (cdb),
    .o_req           (mul_req),
    .o_full          (full_mul)
  );

endmodule

// File: source/combo_mul.sv
// multiply station with a three-stage pipeline that never stalls; only the low 32 bits are kept
module combo_mul #(
  parameter int MUL_RS_DEPTH = 2
) (
  input  logic               i_clock,
  input  logic               i_reset,
  input  logic               i_dispatch_valid,
  input  bus_pkg::dispatch_t i_dispatch,
  input  bus_pkg::cdb_t      i_cdb,
  output bus_pkg::cdb_req_t  o_req,
  output logic               o_full
);

  localparam int SEL_BITS = (MUL_RS_DEPTH > 1) ? $clog2(MUL_RS_DEPTH) : 1;

  logic [MUL_RS_DEPTH-1:0] valid_q;
  logic [MUL_RS_DEPTH-1:0] valid_d;
  bus_pkg::dispatch_t      entry_q [MUL_RS_DEPTH];
  bus_pkg::dispatch_t      entry_d [MUL_RS_DEPTH];
  logic                    take;
  logic                    placed;
  logic                    start;
  logic [SEL_BITS-1:0]     sel;
  logic                    s1_valid;
  logic                    s2_valid;
  logic                    s3_valid;
  core_pkg::tag_t          s1_tag;
  core_pkg::tag_t          s2_tag;
  core_pkg::tag_t          s3_tag;
  core_pkg::word_t         s1_a;
  core_pkg::word_t         s1_b;
  core_pkg::word_t         s2_lo;
  logic [15:0]             s2_hi;
  core_pkg::word_t         s3_value;

  assign take   = i_dispatch_valid && (i_dispatch.opcode == core_pkg::OP_MUL);
  assign o_full = valid_q[MUL_RS_DEPTH-1];
  assign o_req  = '{req: s3_valid, tag: s3_tag, value: s3_value};

  always_comb begin
    start = 1'b0;
    sel   = '0;
    for (int i = MUL_RS_DEPTH - 1; i >= 0; i--) begin
      if (valid_q[i] && entry_q[i].op1.ready && entry_q[i].op2.ready) begin
        start = 1'b1;
        sel   = SEL_BITS'(i);
      end
    end
  end

  always_comb begin
    valid_d = valid_q;
    placed  = 1'b0;
    for (int i = 0; i < MUL_RS_DEPTH; i++) begin
      entry_d[i]     = entry_q[i];
      entry_d[i].op1 = bus_pkg::snoop_operand(entry_q[i].op1, i_cdb);
      entry_d[i].op2 = bus_pkg::snoop_operand(entry_q[i].op2, i_cdb);
    end
    if (start) begin
      for (int i = 0; i < MUL_RS_DEPTH - 1; i++) begin
        if (i >= int'(sel)) begin
          valid_d[i] = valid_d[i+1];
          entry_d[i] = entry_d[i+1];
        end
      end
      valid_d[MUL_RS_DEPTH-1] = 1'b0;
    end
    if (take) begin
      for (int i = 0; i < MUL_RS_DEPTH; i++) begin
        if (!placed && !valid_d[i]) begin
          valid_d[i] = 1'b1;
          entry_d[i] = i_dispatch;
          placed     = 1'b1;
        end
      end
    end
  end

  // stage two forms two partial products, stage three adds them
  always_ff @(posedge i_clock) begin
    entry_q  <= entry_d;
    s1_tag   <= entry_q[sel].tag;
    s1_a     <= entry_q[sel].op1.value;
    s1_b     <= entry_q[sel].op2.value;
    s2_tag   <= s1_tag;
    s2_lo    <= s1_a * {16'b0, s1_b[15:0]};
    s2_hi    <= s1_a[15:0] * s1_b[31:16];
    s3_tag   <= s2_tag;
    s3_value <= s2_lo + {s2_hi, 16'b0};
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      valid_q  <= '0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      valid_q  <= valid_d;
      s1_valid <= start;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  no_write_when_full : assert property (@(posedge i_clock) disable iff (i_reset)
    take |-> !o_full);

endmodule

// File: source/combo_alu.sv
// ALU station; oldest entry sits in slot 0, and a finished result holds until the bus is granted
module combo_alu #(
  parameter int ALU_RS_DEPTH = 4
) (
  input  logic               i_clock,
  input  logic               i_reset,
  input  logic               i_dispatch_valid,
  input  bus_pkg::dispatch_t i_dispatch,
  input  bus_pkg::cdb_t      i_cdb,
  input  logic               i_grant,
  output bus_pkg::cdb_req_t  o_req,
  output logic               o_full
);

  localparam int SEL_BITS = (ALU_RS_DEPTH > 1) ? $clog2(ALU_RS_DEPTH) : 1;

  logic [ALU_RS_DEPTH-1:0] valid_q;
  logic [ALU_RS_DEPTH-1:0] valid_d;
  bus_pkg::dispatch_t      entry_q [ALU_RS_DEPTH];
  bus_pkg::dispatch_t      entry_d [ALU_RS_DEPTH];
  logic                    take;
  logic                    placed;
  logic                    ready_found;
  logic [SEL_BITS-1:0]     sel;
  logic                    issue_fire;
  core_pkg::word_t         op_a;
  core_pkg::word_t         op_b;
  core_pkg::word_t         result;
  bus_pkg::cdb_req_t       out_q;

  assign take   = i_dispatch_valid && (i_dispatch.opcode != core_pkg::OP_MUL);
  // entries stay packed toward slot 0, so the last slot tells fullness
  assign o_full = valid_q[ALU_RS_DEPTH-1];
  assign o_req  = out_q;

  // scan from the top so the lowest, oldest ready slot is kept
  always_comb begin
    ready_found = 1'b0;
    sel         = '0;
    for (int i = ALU_RS_DEPTH - 1; i >= 0; i--) begin
      if (valid_q[i] && entry_q[i].op1.ready && entry_q[i].op2.ready) begin
        ready_found = 1'b1;
        sel         = SEL_BITS'(i);
      end
    end
  end

  assign issue_fire = ready_found && (!out_q.req || i_grant);

  // ADDI reaches the station with the immediate already placed in op2
  assign op_a = entry_q[sel].op1.value;
  assign op_b = entry_q[sel].op2.value;

  always_comb begin
    case (entry_q[sel].opcode)
      core_pkg::OP_SUB: result = op_a - op_b;
      core_pkg::OP_AND: result = op_a & op_b;
      core_pkg::OP_OR:  result = op_a | op_b;
      core_pkg::OP_XOR: result = op_a ^ op_b;
      default:          result = op_a + op_b;
    endcase
  end

  always_comb begin
    valid_d = valid_q;
    placed  = 1'b0;
    for (int i = 0; i < ALU_RS_DEPTH; i++) begin
      entry_d[i]     = entry_q[i];
      entry_d[i].op1 = bus_pkg::snoop_operand(entry_q[i].op1, i_cdb);
      entry_d[i].op2 = bus_pkg::snoop_operand(entry_q[i].op2, i_cdb);
    end
    // close the gap left by the issued entry
    if (issue_fire) begin
      for (int i = 0; i < ALU_RS_DEPTH - 1; i++) begin
        if (i >= int'(sel)) begin
          valid_d[i] = valid_d[i+1];
          entry_d[i] = entry_d[i+1];
        end
      end
      valid_d[ALU_RS_DEPTH-1] = 1'b0;
    end
    if (take) begin
      for (int i = 0; i < ALU_RS_DEPTH; i++) begin
        if (!placed && !valid_d[i]) begin
          valid_d[i] = 1'b1;
          entry_d[i] = i_dispatch;
          placed     = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clock) begin
    entry_q <= entry_d;
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      valid_q   <= '0;
      out_q.req <= 1'b0;
    end else begin
      valid_q <= valid_d;
      if (issue_fire) begin
        out_q.req   <= 1'b1;
        out_q.tag   <= entry_q[sel].tag;
        out_q.value <= result;
      end else if (i_grant) begin
        out_q.req <= 1'b0;
      end
    end
  end

  no_write_when_full : assert property (@(posedge i_clock) disable iff (i_reset)
    take |-> !o_full);

endmodule

// File: source/reorder_buffer.sv
// circular reorder buffer and bus arbiter; the multiplier always wins, one retire per cycle
module reorder_buffer #(
  parameter int ROB_SIZE_BITS = 3
) (
  input  logic               i_clock,
  input  logic               i_reset,
  input  logic               i_alloc_valid,
  input  core_pkg::reg_idx_t i_alloc_rd,
  input  bus_pkg::cdb_req_t  i_alu_req,
  input  bus_pkg::cdb_req_t  i_mul_req,
  output core_pkg::tag_t     o_alloc_tag,
  output logic               o_alu_grant,
  output bus_pkg::cdb_t      o_cdb,
  output logic               o_full,
  output logic               o_retire_valid,
  output bus_pkg::retire_t   o_retire
);

  localparam int ROB_SIZE = 1 << ROB_SIZE_BITS;

  core_pkg::reg_idx_t       rd_q    [ROB_SIZE];
  core_pkg::word_t          value_q [ROB_SIZE];
  logic [ROB_SIZE-1:0]      done_q;
  logic [ROB_SIZE_BITS-1:0] head_q;
  logic [ROB_SIZE_BITS-1:0] tail_q;
  logic [ROB_SIZE_BITS:0]   count_q;
  logic [ROB_SIZE_BITS-1:0] cdb_idx;
  logic [ROB_SIZE_BITS-1:0] cdb_offset;

  // the multiplier pipeline cannot hold a result, so it is never refused
  always_comb begin
    o_alu_grant = 1'b0;
    o_cdb.valid = 1'b0;
    o_cdb.tag   = i_alu_req.tag;
    o_cdb.value = i_alu_req.value;
    if (i_mul_req.req) begin
      o_cdb.valid = 1'b1;
      o_cdb.tag   = i_mul_req.tag;
      o_cdb.value = i_mul_req.value;
    end else if (i_alu_req.req) begin
      o_cdb.valid = 1'b1;
      o_alu_grant = 1'b1;
    end
  end

  assign cdb_idx     = o_cdb.tag[ROB_SIZE_BITS-1:0];
  assign o_alloc_tag = core_pkg::tag_t'(tail_q);

  // count reaches ROB_SIZE only when every entry is taken, which sets its top bit
  assign o_full = count_q[ROB_SIZE_BITS];

  assign o_retire_valid = (count_q != '0) && done_q[head_q];
  assign o_retire.rd    = rd_q[head_q];
  assign o_retire.tag   = core_pkg::tag_t'(head_q);
  assign o_retire.value = value_q[head_q];

  always_ff @(posedge i_clock) begin
    if (i_alloc_valid) begin
      rd_q[tail_q] <= i_alloc_rd;
    end
    if (o_cdb.valid) begin
      value_q[cdb_idx] <= o_cdb.value;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (i_alloc_valid) begin
        tail_q         <= tail_q + 1'b1;
        done_q[tail_q] <= 1'b0;
      end
      if (o_cdb.valid) begin
        done_q[cdb_idx] <= 1'b1;
      end
      if (o_retire_valid) begin
        head_q <= head_q + 1'b1;
      end
      if (i_alloc_valid && !o_retire_valid) begin
        count_q <= count_q + 1'b1;
      end else if (!i_alloc_valid && o_retire_valid) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // distance from the head tells whether the broadcast slot is live
  assign cdb_offset = cdb_idx - head_q;

  cdb_hits_live_entry : assert property (@(posedge i_clock) disable iff (i_reset)
    o_cdb.valid |-> ({1'b0, cdb_offset} < count_q) && !done_q[cdb_idx]);

  no_alloc_when_full : assert property (@(posedge i_clock) disable iff (i_reset)
    i_alloc_valid |-> !o_full);

endmodule

// File: source/register_file.sv
// register values with rename tags; values update on broadcast, not at retire, as there is no flush
module register_file (
  input  logic               i_clock,
  input  logic               i_reset,
  input  logic               i_rename_valid,
  input  core_pkg::reg_idx_t i_rename_rd,
  input  core_pkg::tag_t     i_rename_tag,
  input  core_pkg::reg_idx_t i_rs1,
  input  core_pkg::reg_idx_t i_rs2,
  input  bus_pkg::cdb_t      i_cdb,
  output bus_pkg::operand_t  o_rs1,
  output bus_pkg::operand_t  o_rs2
);

  core_pkg::word_t                value_q [core_pkg::REG_COUNT];
  core_pkg::tag_t                 tag_q   [core_pkg::REG_COUNT];
  logic [core_pkg::REG_COUNT-1:0] busy_q;

  // a busy register hands out its tag, unless that tag is on the bus right now
  function automatic bus_pkg::operand_t lookup(core_pkg::reg_idx_t idx);
    bus_pkg::operand_t op;
    op.ready = !busy_q[idx];
    op.tag   = tag_q[idx];
    op.value = value_q[idx];
    return bus_pkg::snoop_operand(op, i_cdb);
  endfunction

  always_comb begin
    o_rs1 = lookup(i_rs1);
    o_rs2 = lookup(i_rs2);
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      busy_q <= '0;
      for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
        value_q[i] <= '0;
        tag_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
        // an older producer whose tag was replaced must not write
        if (i_cdb.valid && busy_q[i] && tag_q[i] == i_cdb.tag) begin
          value_q[i] <= i_cdb.value;
          busy_q[i]  <= 1'b0;
        end
      end
      // placed last so a rename wins over a clear in the same cycle
      if (i_rename_valid) begin
        busy_q[i_rename_rd] <= 1'b1;
        tag_q[i_rename_rd]  <= i_rename_tag;
      end
    end
  end

endmodule

// File: source/bus_pkg.sv
// internal bus formats of the cluster; one result bus, operands carry either a value or a tag
package bus_pkg;

  // instruction as presented at the core input, in program order
  typedef struct packed {
    core_pkg::opcode_e  opcode;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::word_t    imm;
  } issue_t;

  // when ready is low the value is meaningless and tag names the producer
  typedef struct packed {
    logic            ready;
    core_pkg::tag_t  tag;
    core_pkg::word_t value;
  } operand_t;

  typedef struct packed {
    core_pkg::opcode_e opcode;
    core_pkg::tag_t    tag;
    operand_t          op1;
    operand_t          op2;
  } dispatch_t;

  typedef struct packed {
    logic            valid;
    core_pkg::tag_t  tag;
    core_pkg::word_t value;
  } cdb_t;

  typedef struct packed {
    core_pkg::reg_idx_t rd;
    core_pkg::tag_t     tag;
    core_pkg::word_t    value;
  } retire_t;

  typedef struct packed {
    logic            req;
    core_pkg::tag_t  tag;
    core_pkg::word_t value;
  } cdb_req_t;

  // picks up a broadcast result for an operand still waiting on that tag
  function automatic operand_t snoop_operand(operand_t op, cdb_t cdb);
    operand_t result;
    result = op;
    if (!op.ready && cdb.valid && cdb.tag == op.tag) begin
      result.ready = 1'b1;
      result.value = cdb.value;
    end
    return result;
  endfunction

endpackage

// File: source/core_pkg.sv
// instruction set constants: 32-bit data, eight writable registers, tags limit the ROB to 8 entries
package core_pkg;

  // data path width for every register, operand and result
  localparam int XLEN = 32;

  // all registers are general purpose, none is hardwired to zero
  localparam int REG_COUNT = 8;
  localparam int REG_BITS = $clog2(REG_COUNT);

  // a tag names one reorder buffer entry, so the buffer never grows past 2**TAG_BITS
  localparam int TAG_BITS = 3;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_BITS-1:0] reg_idx_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  // ADDI takes its second operand from the immediate field.
  // MUL keeps only the low XLEN bits of the product
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ADDI = 3'd5,
    OP_MUL  = 3'd6
  } opcode_e;

endpackage
